//--- source/pcim_pkg.sv
// pcim host memory model, shared widths, types and response codes
package pcim_pkg;

   // --------------------------------------------------
   // geometry
   // --------------------------------------------------
   localparam int LINE_BYTES      = 64;
   localparam int DWORDS_PER_LINE = 16;
   localparam int BYTES_PER_DWORD = LINE_BYTES / DWORDS_PER_LINE;
   localparam int LINE_LSB        = $clog2(LINE_BYTES);    // byte offset bits in an address
   localparam int MEM_LINES       = 64;

   // pending commands per direction
   localparam int CMD_DEPTH = 4;
   localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
   localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

   // --------------------------------------------------
   // bus and memory types
   // --------------------------------------------------
   typedef logic [63:0]                    addr_t;
   typedef logic [4:0]                     id_t;
   typedef logic [7:0]                     len_t;    // beats minus one
   typedef logic [LINE_BYTES*8-1:0]        data_t;
   typedef logic [LINE_BYTES-1:0]          strb_t;
   typedef logic [1:0]                     resp_t;
   typedef logic [$clog2(MEM_LINES)-1:0]   line_idx_t;
   typedef logic [DWORDS_PER_LINE-1:0]     dword_flags_t;
   typedef logic [CMD_PTR_W-1:0]           cmd_ptr_t;
   typedef logic [CMD_CNT_W-1:0]           cmd_cnt_t;

   localparam logic [31:0] DEFAULT_DWORD = 32'hFFFF_FFFF;   // never written
   localparam resp_t       RESP_OKAY     = 2'b00;

   // read engine states
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_BEAT
   } rd_state_t;

endpackage

//--- source/pcim_wr_intake.sv
// pcim write intake, queues AW commands and turns W beats into memory line writes
`timescale 1ns/1ps

module pcim_wr_intake (
   input  logic                  clk_core,
   input  logic                  sync_rst_n,
   input  pcim_pkg::id_t         awid_i,
   input  pcim_pkg::addr_t       awaddr_i,
   input  pcim_pkg::len_t        awlen_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  pcim_pkg::data_t       wdata_i,
   input  pcim_pkg::strb_t       wstrb_i,
   input  logic                  wlast_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   input  logic                  b_accept_i,
   output logic                  mem_we_o,
   output pcim_pkg::line_idx_t   mem_wline_o,
   output pcim_pkg::data_t       mem_wdata_o,
   output pcim_pkg::strb_t       mem_wstrb_o,
   output logic                  done_o,
   output pcim_pkg::id_t         done_id_o
);
   import pcim_pkg::*;

   id_t       cmd_id   [CMD_DEPTH];
   line_idx_t cmd_line [CMD_DEPTH];
   len_t      cmd_len  [CMD_DEPTH];
   cmd_ptr_t  wr_ptr;
   cmd_ptr_t  rd_ptr;
   cmd_cnt_t  cmd_cnt;       // commands still owed W beats
   cmd_cnt_t  out_cnt;       // writes between AW and B
   cmd_cnt_t  out_cnt_nxt;
   len_t      beat_cnt;
   logic      aw_fire;
   logic      w_fire;
   logic      w_done;

   assign aw_fire     = awvalid_i & awready_o;
   assign w_fire      = wvalid_i & wready_o;
   assign w_done      = w_fire & wlast_i;
   assign out_cnt_nxt = out_cnt + cmd_cnt_t'(aw_fire) - cmd_cnt_t'(b_accept_i);

   // --------------------------------------------------
   // AW command fifo
   // --------------------------------------------------
   always_ff @(posedge clk_core) begin
      if (aw_fire) begin
         cmd_id[wr_ptr]   <= awid_i;
         cmd_line[wr_ptr] <= line_idx_t'(awaddr_i >> LINE_LSB);   // offset bits dropped
         cmd_len[wr_ptr]  <= awlen_i;
      end
   end

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         cmd_cnt   <= '0;
         out_cnt   <= '0;
         awready_o <= 1'b0;
         beat_cnt  <= '0;
         done_o    <= 1'b0;
      end else begin
         if (aw_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (w_done) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         cmd_cnt   <= cmd_cnt + cmd_cnt_t'(aw_fire) - cmd_cnt_t'(w_done);
         out_cnt   <= out_cnt_nxt;
         awready_o <= (out_cnt_nxt < cmd_cnt_t'(CMD_DEPTH));
         if (w_done) begin
            beat_cnt <= '0;
         end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
         done_o <= w_done;   // completion one cycle after wlast
      end
   end

   always_ff @(posedge clk_core) begin
      if (w_done) begin
         done_id_o <= cmd_id[rd_ptr];
      end
   end

   // --------------------------------------------------
   // W beats to line writes
   // --------------------------------------------------
   assign wready_o    = (cmd_cnt != '0);
   assign mem_we_o    = w_fire;
   assign mem_wline_o = cmd_line[rd_ptr] + line_idx_t'(beat_cnt);   // wraps mod 64
   assign mem_wdata_o = wdata_i;
   assign mem_wstrb_o = wstrb_i;

   // wlast must line up with the burst length taken on AW
   a_wlast_on_len: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      w_fire |-> (wlast_i == (beat_cnt == cmd_len[rd_ptr])));

endmodule

//--- source/host_mem.sv
// host memory of 64 lines with byte strobes, unwritten dwords read back as all ones
`timescale 1ns/1ps

module host_mem (
   input  logic                  clk_core,
   input  logic                  sync_rst_n,
   input  logic                  we_i,
   input  pcim_pkg::line_idx_t   wline_i,
   input  pcim_pkg::data_t       wdata_i,
   input  pcim_pkg::strb_t       wstrb_i,
   input  logic                  re_i,
   input  pcim_pkg::line_idx_t   rline_i,
   output pcim_pkg::data_t       rdata_o
);
   import pcim_pkg::*;

   data_t        mem   [MEM_LINES];
   dword_flags_t flags [MEM_LINES];   // dword has been written
   dword_flags_t wr_touch;

   // dwords hit by at least one strobe
   always_comb begin
      for (int d = 0; d < DWORDS_PER_LINE; d++) begin
         wr_touch[d] = |wstrb_i[BYTES_PER_DWORD*d +: BYTES_PER_DWORD];
      end
   end

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         for (int i = 0; i < MEM_LINES; i++) begin
            flags[i] <= '0;
         end
      end else if (we_i) begin
         flags[wline_i] <= flags[wline_i] | wr_touch;
      end
   end

   // --------------------------------------------------
   // data array and registered read port
   // --------------------------------------------------
   always_ff @(posedge clk_core) begin
      if (we_i) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (wstrb_i[b]) begin
               mem[wline_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end else if (!flags[wline_i][b / BYTES_PER_DWORD]) begin
               mem[wline_i][8*b +: 8] <= 8'hFF;   // merge into ones
            end
         end
      end
      if (re_i) begin
         for (int d = 0; d < DWORDS_PER_LINE; d++) begin
            rdata_o[32*d +: 32] <= flags[rline_i][d] ? mem[rline_i][32*d +: 32]
                                                     : DEFAULT_DWORD;
         end
      end
   end

endmodule

//--- source/pcim_rd_engine.sv
// pcim read engine, queues AR commands and plays memory lines back as R beats
`timescale 1ns/1ps

module pcim_rd_engine (
   input  logic                  clk_core,
   input  logic                  sync_rst_n,
   input  pcim_pkg::id_t         arid_i,
   input  pcim_pkg::addr_t       araddr_i,
   input  pcim_pkg::len_t        arlen_i,
   input  logic                  arvalid_i,
   output logic                  arready_o,
   output pcim_pkg::id_t         rid_o,
   output pcim_pkg::data_t       rdata_o,
   output pcim_pkg::resp_t       rresp_o,
   output logic                  rlast_o,
   output logic                  rvalid_o,
   input  logic                  rready_i,
   output logic                  mem_re_o,
   output pcim_pkg::line_idx_t   mem_rline_o,
   input  pcim_pkg::data_t       mem_rdata_i
);
   import pcim_pkg::*;

   id_t       cmd_id   [CMD_DEPTH];
   line_idx_t cmd_line [CMD_DEPTH];
   len_t      cmd_len  [CMD_DEPTH];
   cmd_ptr_t  wr_ptr;
   cmd_ptr_t  rd_ptr;
   cmd_cnt_t  cmd_cnt;
   cmd_cnt_t  cmd_cnt_nxt;
   len_t      beat_cnt;
   rd_state_t state;
   logic      ar_fire;
   logic      r_fire;
   logic      last_beat;
   logic      r_done;

   assign ar_fire     = arvalid_i & arready_o;
   assign r_fire      = rvalid_o & rready_i;
   assign last_beat   = (beat_cnt == cmd_len[rd_ptr]);
   assign r_done      = r_fire & last_beat;
   assign cmd_cnt_nxt = cmd_cnt + cmd_cnt_t'(ar_fire) - cmd_cnt_t'(r_done);

   // --------------------------------------------------
   // AR command fifo
   // --------------------------------------------------
   always_ff @(posedge clk_core) begin
      if (ar_fire) begin
         cmd_id[wr_ptr]   <= arid_i;
         cmd_line[wr_ptr] <= line_idx_t'(araddr_i >> LINE_LSB);
         cmd_len[wr_ptr]  <= arlen_i;
      end
   end

   // --------------------------------------------------
   // beat sequencer
   // --------------------------------------------------
   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         cmd_cnt   <= '0;
         arready_o <= 1'b0;
         beat_cnt  <= '0;
         state     <= RD_IDLE;
      end else begin
         if (ar_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (r_done) begin
            rd_ptr <= rd_ptr + 1'b1;   // command retires after its last beat
         end
         cmd_cnt   <= cmd_cnt_nxt;
         arready_o <= (cmd_cnt_nxt < cmd_cnt_t'(CMD_DEPTH));
         case (state)
            RD_IDLE: begin
               if (cmd_cnt != '0) begin
                  state <= RD_FETCH;
               end
            end
            RD_FETCH: state <= RD_BEAT;   // memory answers next cycle
            RD_BEAT: begin
               if (r_fire) begin
                  if (last_beat) begin
                     beat_cnt <= '0;
                     state    <= RD_IDLE;
                  end else begin
                     beat_cnt <= beat_cnt + 1'b1;
                     state    <= RD_FETCH;
                  end
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   assign mem_re_o    = (state == RD_FETCH);
   assign mem_rline_o = cmd_line[rd_ptr] + line_idx_t'(beat_cnt);

   // memory output only moves on a fetch, so the beat holds under stalls
   assign rvalid_o = (state == RD_BEAT);
   assign rdata_o  = mem_rdata_i;
   assign rid_o    = cmd_id[rd_ptr];
   assign rresp_o  = RESP_OKAY;
   assign rlast_o  = rvalid_o & last_beat;

   a_r_hold: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)));

endmodule

//--- source/pcim_bresp_gen.sv
// pcim write response generator, one OKAY on the B channel per finished burst
`timescale 1ns/1ps

module pcim_bresp_gen (
   input  logic               clk_core,
   input  logic               sync_rst_n,
   input  logic               done_i,
   input  pcim_pkg::id_t      done_id_i,
   output pcim_pkg::id_t      bid_o,
   output pcim_pkg::resp_t    bresp_o,
   output logic               bvalid_o,
   input  logic               bready_i,
   output logic               b_accept_o
);
   import pcim_pkg::*;

   id_t      q_id [CMD_DEPTH];   // completions in order
   cmd_ptr_t wr_ptr;
   cmd_ptr_t rd_ptr;
   cmd_cnt_t q_cnt;

   always_ff @(posedge clk_core) begin
      if (done_i) begin
         q_id[wr_ptr] <= done_id_i;
      end
   end

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
      end else begin
         if (done_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (b_accept_o) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         q_cnt <= q_cnt + cmd_cnt_t'(done_i) - cmd_cnt_t'(b_accept_o);
      end
   end

   // --------------------------------------------------
   // B channel
   // --------------------------------------------------
   assign bvalid_o   = (q_cnt != '0);
   assign bid_o      = q_id[rd_ptr];
   assign bresp_o    = RESP_OKAY;
   assign b_accept_o = bvalid_o & bready_i;   // frees an outstanding slot in the intake

   // intake limits outstanding writes, so a full queue never sees a completion
   a_no_push_full: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      done_i |-> (q_cnt != cmd_cnt_t'(CMD_DEPTH)));

endmodule

//--- source/pcim_host_top.sv
// pcim host side top, write intake, host memory, read engine and B response generator
`timescale 1ns/1ps

module pcim_host_top (
   input  logic                  clk_core,
   input  logic                  sync_rst_n,

   // write address and data
   input  pcim_pkg::id_t         awid_i,
   input  pcim_pkg::addr_t       awaddr_i,
   input  pcim_pkg::len_t        awlen_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  pcim_pkg::data_t       wdata_i,
   input  pcim_pkg::strb_t       wstrb_i,
   input  logic                  wlast_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,

   // write response
   output pcim_pkg::id_t         bid_o,
   output pcim_pkg::resp_t       bresp_o,
   output logic                  bvalid_o,
   input  logic                  bready_i,

   // read address and data
   input  pcim_pkg::id_t         arid_i,
   input  pcim_pkg::addr_t       araddr_i,
   input  pcim_pkg::len_t        arlen_i,
   input  logic                  arvalid_i,
   output logic                  arready_o,
   output pcim_pkg::id_t         rid_o,
   output pcim_pkg::data_t       rdata_o,
   output pcim_pkg::resp_t       rresp_o,
   output logic                  rlast_o,
   output logic                  rvalid_o,
   input  logic                  rready_i
);
   import pcim_pkg::*;

   logic      mem_we;
   line_idx_t mem_wline;
   data_t     mem_wdata;
   strb_t     mem_wstrb;
   logic      mem_re;
   line_idx_t mem_rline;
   data_t     mem_rdata;
   logic      done;
   id_t       done_id;
   logic      b_accept;

   pcim_wr_intake u_wr_intake (
      .clk_core    (clk_core),
      .sync_rst_n  (sync_rst_n),
      .awid_i      (awid_i),
      .awaddr_i    (awaddr_i),
      .awlen_i     (awlen_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wlast_i     (wlast_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .b_accept_i  (b_accept),
      .mem_we_o    (mem_we),
      .mem_wline_o (mem_wline),
      .mem_wdata_o (mem_wdata),
      .mem_wstrb_o (mem_wstrb),
      .done_o      (done),
      .done_id_o   (done_id)
   );

   host_mem u_host_mem (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .we_i       (mem_we),
      .wline_i    (mem_wline),
      .wdata_i    (mem_wdata),
      .wstrb_i    (mem_wstrb),
      .re_i       (mem_re),
      .rline_i    (mem_rline),
      .rdata_o    (mem_rdata)
   );

   pcim_rd_engine u_rd_engine (
      .clk_core    (clk_core),
      .sync_rst_n  (sync_rst_n),
      .arid_i      (arid_i),
      .araddr_i    (araddr_i),
      .arlen_i     (arlen_i),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .rid_o       (rid_o),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .rlast_o     (rlast_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .mem_re_o    (mem_re),
      .mem_rline_o (mem_rline),
      .mem_rdata_i (mem_rdata)
   );

   pcim_bresp_gen u_bresp_gen (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .done_i     (done),
      .done_id_i  (done_id),
      .bid_o      (bid_o),
      .bresp_o    (bresp_o),
      .bvalid_o   (bvalid_o),
      .bready_i   (bready_i),
      .b_accept_o (b_accept)
   );

endmodule

//--- verification/pcim_host_tests.svh
// pcim host directed tests, one task per behavior, included by the testbench
`ifndef PCIM_HOST_TESTS_SVH
`define PCIM_HOST_TESTS_SVH

   // called on the falling edge where reset is released
   task automatic test_reset_state();
      int errs;
      errs = err_cnt;
      compare_bit("awready_o", awready, 1'b0);
      compare_bit("wready_o", wready, 1'b0);
      compare_bit("arready_o", arready, 1'b0);
      compare_bit("bvalid_o", bvalid, 1'b0);
      compare_bit("rvalid_o", rvalid, 1'b0);
      @(negedge clk_core);
      compare_bit("awready_o", awready, 1'b1);   // one cycle after release
      compare_bit("arready_o", arready, 1'b1);
      read_burst(5'd1, 6'd5, 8'd0, 1'b0);        // never written line
      finish_test("reset_state", errs);
   endtask

   task automatic test_single_write();
      int errs;
      errs = err_cnt;
      write_burst(5'd3, 6'd10, 8'd0, '1);
      collect_b(5'd3);
      read_burst(5'd7, 6'd10, 8'd0, 1'b0);
      finish_test("single_write", errs);
   endtask

   task automatic test_partial_strobes();
      int errs;
      errs = err_cnt;
      // dwords 0, 2 and 9 touched, only 9 fully
      write_burst(5'd4, 6'd20, 8'd0, 64'h0000_00F0_0000_0C03);
      collect_b(5'd4);
      // fills the rest of dword 0, half of dword 3
      write_burst(5'd5, 6'd20, 8'd0, 64'h0000_0000_0000_300C);
      collect_b(5'd5);
      read_burst(5'd6, 6'd20, 8'd0, 1'b0);
      finish_test("partial_strobes", errs);
   endtask

   task automatic test_wrap_burst();
      int errs;
      errs = err_cnt;
      write_burst(5'd9, 6'd62, 8'd3, '1);   // lines 62, 63, 0, 1
      collect_b(5'd9);
      read_burst(5'd10, 6'd62, 8'd3, 1'b0);
      finish_test("wrap_burst", errs);
   endtask

   task automatic test_read_stalls();
      int errs;
      errs = err_cnt;
      write_burst(5'd12, 6'd30, 8'd3, '1);
      collect_b(5'd12);
      read_burst(5'd13, 6'd30, 8'd3, 1'b1);
      read_burst(5'd14, 6'd62, 8'd3, 1'b1);
      finish_test("read_stalls", errs);
   endtask

   task automatic test_b_backpressure();
      int errs;
      int n;
      errs = err_cnt;
      bready = 1'b0;
      for (int i = 0; i < CMD_DEPTH; i++) begin
         write_burst(id_t'(20 + i), line_idx_t'(40 + i), 8'd0, '1);
      end
      while (!bvalid) @(negedge clk_core);
      compare_bit("awready_o", awready, 1'b0);   // all slots held by B
      collect_b(5'd20);
      n = 0;
      while (!awready && n < 4) begin
         @(negedge clk_core);
         n++;
      end
      if (!awready) begin
         $display("awready_o stayed low after a B was accepted");
      end
      compare_bit("awready_o", awready, 1'b1);
      for (int i = 1; i < CMD_DEPTH; i++) begin
         collect_b(id_t'(20 + i));
      end
      read_burst(5'd24, 6'd40, 8'd3, 1'b0);
      finish_test("b_backpressure", errs);
   endtask

`endif

//--- verification/pcim_host_tb.sv
// pcim host testbench driving the AXI style channels and checking against a line model
`timescale 1ns/1ps

module pcim_host_tb;
   import pcim_pkg::*;

   localparam int BURSTS          = 16;                  // bursts issued over all tests
   localparam int WATCHDOG_CYCLES = BURSTS * 200 + 100;

   logic      clk_core;
   logic      sync_rst_n;
   id_t       awid;
   addr_t     awaddr;
   len_t      awlen;
   logic      awvalid;
   logic      awready;
   data_t     wdata;
   strb_t     wstrb;
   logic      wlast;
   logic      wvalid;
   logic      wready;
   id_t       bid;
   resp_t     bresp;
   logic      bvalid;
   logic      bready;
   id_t       arid;
   addr_t     araddr;
   len_t      arlen;
   logic      arvalid;
   logic      arready;
   id_t       rid;
   data_t     rdata;
   resp_t     rresp;
   logic      rlast;
   logic      rvalid;
   logic      rready;

   data_t       model_mem [MEM_LINES];
   logic [31:0] rng_state = 32'd69101;
   int          check_cnt = 0;
   int          err_cnt = 0;
   int          test_cnt = 0;
   int          test_fail_cnt = 0;

   pcim_host_top pcim_host_top_i (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .awid_i     (awid),
      .awaddr_i   (awaddr),
      .awlen_i    (awlen),
      .awvalid_i  (awvalid),
      .awready_o  (awready),
      .wdata_i    (wdata),
      .wstrb_i    (wstrb),
      .wlast_i    (wlast),
      .wvalid_i   (wvalid),
      .wready_o   (wready),
      .bid_o      (bid),
      .bresp_o    (bresp),
      .bvalid_o   (bvalid),
      .bready_i   (bready),
      .arid_i     (arid),
      .araddr_i   (araddr),
      .arlen_i    (arlen),
      .arvalid_i  (arvalid),
      .arready_o  (arready),
      .rid_o      (rid),
      .rdata_o    (rdata),
      .rresp_o    (rresp),
      .rlast_o    (rlast),
      .rvalid_o   (rvalid),
      .rready_i   (rready)
   );

   initial begin
      clk_core = 1'b0;
      forever #4 clk_core = ~clk_core;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_core);
      $display("watchdog expired after %0d cycles, a handshake never completed",
               WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   // --------------------------------------------------
   // random numbers and the memory model
   // --------------------------------------------------
   function automatic logic [31:0] xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic data_t rand_data();
      data_t d;
      for (int i = 0; i < DWORDS_PER_LINE; i++) begin
         d[32*i +: 32] = xorshift32();
      end
      return d;
   endfunction

   // every byte starts as ones, so partial writes merge into ones
   function automatic void model_write(input line_idx_t line, input data_t data,
                                       input strb_t strb);
      for (int b = 0; b < LINE_BYTES; b++) begin
         if (strb[b]) begin
            model_mem[line][8*b +: 8] = data[8*b +: 8];
         end
      end
   endfunction

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic compare_data(input string name, input data_t got, input data_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_id(input string name, input id_t got, input id_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_resp(input string name, input resp_t got, input resp_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch at %0d ns: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch at %0d ns: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      test_cnt++;
      if (err_cnt == err_before) begin
         $display("test %s: ok", name);
      end else begin
         test_fail_cnt++;
         $display("test %s: %0d errors", name, err_cnt - err_before);
      end
   endtask

   // --------------------------------------------------
   // channel drivers changing inputs on the falling edge
   // --------------------------------------------------
   task automatic write_burst(input id_t id, input line_idx_t line, input len_t len,
                              input strb_t strb);
      data_t     beat;
      line_idx_t cur;
      awid    = id;
      awaddr  = addr_t'(line) << LINE_LSB;
      awlen   = len;
      awvalid = 1'b1;
      while (!awready) @(negedge clk_core);
      @(negedge clk_core);
      awvalid = 1'b0;
      for (int k = 0; k <= int'(len); k++) begin
         beat   = rand_data();
         cur    = line + line_idx_t'(k);   // wraps at 64 lines
         wdata  = beat;
         wstrb  = strb;
         wlast  = (k == int'(len));
         wvalid = 1'b1;
         while (!wready) @(negedge clk_core);
         @(negedge clk_core);
         model_write(cur, beat, strb);
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
   endtask

   task automatic collect_b(input id_t exp_id);
      bready = 1'b1;
      while (!bvalid) @(negedge clk_core);
      compare_id("bid_o", bid, exp_id);
      compare_resp("bresp_o", bresp, RESP_OKAY);
      @(negedge clk_core);
      bready = 1'b0;
   endtask

   task automatic read_burst(input id_t id, input line_idx_t line, input len_t len,
                             input logic stall);
      int        k;
      line_idx_t cur;
      arid    = id;
      araddr  = addr_t'(line) << LINE_LSB;
      arlen   = len;
      arvalid = 1'b1;
      while (!arready) @(negedge clk_core);
      @(negedge clk_core);
      arvalid = 1'b0;
      k = 0;
      while (k <= int'(len)) begin
         rready = stall ? ((xorshift32() % 3) != 0) : 1'b1;
         if (rvalid && rready) begin
            cur = line + line_idx_t'(k);
            compare_data($sformatf("rdata_o beat %0d", k), rdata, model_mem[cur]);
            compare_id("rid_o", rid, id);
            compare_resp("rresp_o", rresp, RESP_OKAY);
            compare_bit("rlast_o", rlast, k == int'(len));
            k++;
         end
         @(negedge clk_core);
      end
      rready = 1'b0;
   endtask

`include "pcim_host_tests.svh"

   initial begin
      sync_rst_n = 1'b0;
      awid = '0;
      awaddr = '0;
      awlen = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wlast = 1'b0;
      wvalid = 1'b0;
      bready = 1'b0;
      arid = '0;
      araddr = '0;
      arlen = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      for (int i = 0; i < MEM_LINES; i++) begin
         model_mem[i] = {DWORDS_PER_LINE{DEFAULT_DWORD}};
      end
      repeat (3) @(posedge clk_core);
      @(negedge clk_core);
      sync_rst_n = 1'b1;

      test_reset_state();
      test_single_write();
      test_partial_strobes();
      test_wrap_burst();
      test_read_stalls();
      test_b_backpressure();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, test_fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- tb.f
+incdir+verification
source/pcim_pkg.sv
source/pcim_wr_intake.sv
source/host_mem.sv
source/pcim_rd_engine.sv
source/pcim_bresp_gen.sv
source/pcim_host_top.sv
verification/pcim_host_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the pcim host testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module pcim_host_tb -o pcim_host_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/pcim_host_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
   exit 1
fi
exit 0
